// File: kmul.f
rtl/kmul_arith_pkg.sv
rtl/kmul_timing_pkg.sv
rtl/kmul_split_if.sv
rtl/kmul_delay_line.sv
rtl/kmul_split_stage.sv
rtl/kmul_sub_multiplier.sv
rtl/kmul_execute.sv
rtl/kmul_recombine.sv
rtl/kmul_top.sv
testbench/kmul_tb.sv

// File: rtl/kmul_arith_pkg.sv
/*
 * Karatsuba multiplier arithmetic definitions
 * Operand, half, middle-term and product widths with their word types
 */
`default_nettype none

package kmul_arith_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int OPERAND_W = 114;
  localparam int HALF_W    = 57;
  // Half difference needs one extra bit for its sign
  localparam int DIFF_W    = 58;
  localparam int PRODUCT_W = 228;
  localparam int SUBPROD_W = 114;
  // z2 + z0 + signed cross can pass 2^114
  localparam int MID_W     = 115;

  // ==============================
  // Word types
  // ==============================
  typedef logic [OPERAND_W-1:0]      operand_t;
  typedef logic [HALF_W-1:0]         half_t;
  typedef logic [SUBPROD_W-1:0]      subprod_t;
  typedef logic signed [MID_W-1:0]   mid_t;
  typedef logic [PRODUCT_W-1:0]      product_t;

endpackage

`default_nettype wire

// File: rtl/kmul_delay_line.sv
/*
 * Enable-gated delay line
 * DEPTH register stages of any payload, shifting only while ce is high
 */
`timescale 1ns/1ps
`default_nettype none

module kmul_delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     ce,
  input  payload_t d,
  output payload_t q
);

  payload_t stages [DEPTH];

  generate
    if ($bits(payload_t) == 1) begin : g_ctrl
      // Single-bit control such as valid, cleared on reset
      always_ff @(posedge clk) begin
        if (rst) begin
          for (int i = 0; i < DEPTH; i++) begin
            stages[i] <= '0;
          end
        end else if (ce) begin
          stages[0] <= d;
          for (int i = 1; i < DEPTH; i++) begin
            stages[i] <= stages[i-1];
          end
        end
      end
    end else begin : g_data
      // Wide payload, no reset
      always_ff @(posedge clk) begin
        if (ce) begin
          stages[0] <= d;
          for (int i = 1; i < DEPTH; i++) begin
            stages[i] <= stages[i-1];
          end
        end
      end
    end
  endgenerate

  assign q = stages[DEPTH-1];

endmodule

`default_nettype wire

// File: rtl/kmul_execute.sv
/*
 * Karatsuba execute stage
 * High, low and cross sub-products in parallel, sign and valid kept aligned
 */
`timescale 1ns/1ps
`default_nettype none

module kmul_execute (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ce,
  kmul_split_if.consumer           split,
  output kmul_arith_pkg::subprod_t z2,
  output kmul_arith_pkg::subprod_t z0,
  output kmul_arith_pkg::subprod_t p1,
  output logic                     neg,
  output logic                     valid
);
  import kmul_timing_pkg::*;

  // ==============================
  // Sub-products
  // ==============================
  // z2 = a_hi * b_hi
  kmul_sub_multiplier u_mul_hi (
    .clk  (clk),
    .ce   (ce),
    .x    (split.a_hi),
    .y    (split.b_hi),
    .prod (z2)
  );

  // z0 = a_lo * b_lo
  kmul_sub_multiplier u_mul_lo (
    .clk  (clk),
    .ce   (ce),
    .x    (split.a_lo),
    .y    (split.b_lo),
    .prod (z0)
  );

  // Unsigned cross magnitude, sign applied later
  kmul_sub_multiplier u_mul_cross (
    .clk  (clk),
    .ce   (ce),
    .x    (split.a_mag),
    .y    (split.b_mag),
    .prod (p1)
  );

  // ==============================
  // Sideband alignment
  // ==============================
  kmul_delay_line #(.payload_t(logic), .DEPTH(SUBMUL_LAT)) u_neg_dly (
    .clk (clk), .rst (rst), .ce (ce), .d (split.neg), .q (neg)
  );

  kmul_delay_line #(.payload_t(logic), .DEPTH(SUBMUL_LAT)) u_valid_dly (
    .clk (clk), .rst (rst), .ce (ce), .d (split.valid), .q (valid)
  );

endmodule

`default_nettype wire

// File: rtl/kmul_recombine.sv
/*
 * Karatsuba result stage
 * Signs the cross product, builds the middle term, sums the shifted terms
 */
`timescale 1ns/1ps
`default_nettype none

module kmul_recombine (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ce,
  input  kmul_arith_pkg::subprod_t z2,
  input  kmul_arith_pkg::subprod_t z0,
  input  kmul_arith_pkg::subprod_t p1,
  input  logic                     neg,
  input  logic                     in_valid,
  output kmul_arith_pkg::product_t p,
  output logic                     out_valid
);
  import kmul_arith_pkg::*;
  import kmul_timing_pkg::*;

  mid_t                  cross_s;
  mid_t                  mid_q;
  subprod_t              z2_q;
  subprod_t              z0_q;
  subprod_t              z2_qq;
  subprod_t              z0_qq;
  product_t              p_q;
  logic [RESULT_LAT-1:0] vld_sr;

  // ==============================
  // Datapath
  // ==============================
  always_ff @(posedge clk) begin
    if (ce) begin
      // Cycle 1, signed cross term
      cross_s <= neg ? -mid_t'(p1) : mid_t'(p1);
      z2_q    <= z2;
      z0_q    <= z0;
      // Cycle 2, middle term is a_lo*b_hi + a_hi*b_lo, never negative
      mid_q   <= cross_s + mid_t'(z2_q) + mid_t'(z0_q);
      z2_qq   <= z2_q;
      z0_qq   <= z0_q;
      // Cycle 3, bit 114 of mid is magnitude, so zero-extend
      p_q     <= {z2_qq, z0_qq} + (product_t'($unsigned(mid_q)) << HALF_W);
    end
  end

  // Valid follows the datapath
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_sr <= '0;
    end else if (ce) begin
      vld_sr <= {vld_sr[RESULT_LAT-2:0], in_valid};
    end
  end

  assign p         = p_q;
  assign out_valid = vld_sr[RESULT_LAT-1];

endmodule

`default_nettype wire

// File: rtl/kmul_split_if.sv
/*
 * Decode to execute link
 * Original halves, cross-difference magnitudes, product sign and valid
 */
`timescale 1ns/1ps
`default_nettype none

interface kmul_split_if;
  import kmul_arith_pkg::*;

  // Halves for the z2 and z0 products
  half_t a_hi;
  half_t a_lo;
  half_t b_hi;
  half_t b_lo;
  // |a_lo - a_hi| and |b_hi - b_lo|
  half_t a_mag;
  half_t b_mag;
  // Set when the cross product must be negated
  logic  neg;
  logic  valid;

  modport producer (
    output a_hi, a_lo, b_hi, b_lo, a_mag, b_mag, neg, valid
  );

  modport consumer (
    input a_hi, a_lo, b_hi, b_lo, a_mag, b_mag, neg, valid
  );

endinterface

`default_nettype wire

// File: rtl/kmul_split_stage.sv
/*
 * Karatsuba decode stage
 * Splits operands into halves, forms |a_lo - a_hi| and |b_hi - b_lo|
 * and the sign of their product
 */
`timescale 1ns/1ps
`default_nettype none

module kmul_split_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ce,
  input  kmul_arith_pkg::operand_t a,
  input  kmul_arith_pkg::operand_t b,
  input  logic                   in_valid,
  kmul_split_if.producer         split
);
  import kmul_arith_pkg::*;
  import kmul_timing_pkg::*;

  // Four halves travel together through one delay line
  typedef struct packed {
    half_t a_hi;
    half_t a_lo;
    half_t b_hi;
    half_t b_lo;
  } halves_t;

  halves_t            halves_in;
  halves_t            halves_out;
  logic [DIFF_W-1:0]  a_diff;
  logic [DIFF_W-1:0]  b_diff;

  assign halves_in = '{a_hi: a[OPERAND_W-1:HALF_W], a_lo: a[HALF_W-1:0],
                       b_hi: b[OPERAND_W-1:HALF_W], b_lo: b[HALF_W-1:0]};

  // ==============================
  // Cycle 1, two's complement differences
  // ==============================
  always_ff @(posedge clk) begin
    if (ce) begin
      a_diff <= {1'b0, halves_in.a_lo} - {1'b0, halves_in.a_hi};
      b_diff <= {1'b0, halves_in.b_hi} - {1'b0, halves_in.b_lo};
    end
  end

  // ==============================
  // Cycle 2, magnitudes and sign
  // ==============================
  always_ff @(posedge clk) begin
    if (ce) begin
      // Magnitude always fits in HALF_W bits
      split.a_mag <= a_diff[DIFF_W-1] ? half_t'(-a_diff) : half_t'(a_diff);
      split.b_mag <= b_diff[DIFF_W-1] ? half_t'(-b_diff) : half_t'(b_diff);
      split.neg   <= a_diff[DIFF_W-1] ^ b_diff[DIFF_W-1];
    end
  end

  // Halves wait for the magnitudes
  kmul_delay_line #(.payload_t(halves_t), .DEPTH(DECODE_LAT)) u_halves_dly (
    .clk (clk), .rst (rst), .ce (ce), .d (halves_in), .q (halves_out)
  );

  kmul_delay_line #(.payload_t(logic), .DEPTH(DECODE_LAT)) u_valid_dly (
    .clk (clk), .rst (rst), .ce (ce), .d (in_valid), .q (split.valid)
  );

  assign split.a_hi = halves_out.a_hi;
  assign split.a_lo = halves_out.a_lo;
  assign split.b_hi = halves_out.b_hi;
  assign split.b_lo = halves_out.b_lo;

endmodule

`default_nettype wire

// File: rtl/kmul_sub_multiplier.sv
/*
 * Pipelined 57 x 57 unsigned multiplier
 * Operand, product and retiming registers all on ce for balancing
 */
`timescale 1ns/1ps
`default_nettype none

module kmul_sub_multiplier (
  input  logic                     clk,
  input  logic                     ce,
  input  kmul_arith_pkg::half_t    x,
  input  kmul_arith_pkg::half_t    y,
  output kmul_arith_pkg::subprod_t prod
);
  import kmul_arith_pkg::*;
  import kmul_timing_pkg::*;

  // Product reg plus retiming regs
  localparam int PROD_REGS = SUBMUL_LAT - 1;

  half_t    x_q;
  half_t    y_q;
  subprod_t prod_q [PROD_REGS];

  always_ff @(posedge clk) begin
    if (ce) begin
      // Stage 1, operand capture
      x_q <= x;
      y_q <= y;
      // Stage 2, full-width product
      prod_q[0] <= subprod_t'(x_q) * subprod_t'(y_q);
      // Remaining stages give retiming room
      for (int i = 1; i < PROD_REGS; i++) begin
        prod_q[i] <= prod_q[i-1];
      end
    end
  end

  assign prod = prod_q[PROD_REGS-1];

endmodule

`default_nettype wire

// File: rtl/kmul_timing_pkg.sv
/*
 * Karatsuba multiplier pipeline timing
 * Per-stage latencies in cycles of high clock enable
 */
`default_nettype none

package kmul_timing_pkg;

  // Difference register, then magnitude register
  localparam int DECODE_LAT = 2;
  // Operand regs, product reg, two retiming regs
  localparam int SUBMUL_LAT = 4;
  // Signed cross, middle term, final sum
  localparam int RESULT_LAT = 3;

  // Accepted input to out_valid
  localparam int TOTAL_LAT  = DECODE_LAT + SUBMUL_LAT + RESULT_LAT;

endpackage

`default_nettype wire

// File: rtl/kmul_top.sv
/*
 * 114 x 114 Karatsuba multiplier top level
 * Valid/ready stream ports, one clock enable stalls every stage
 */
`timescale 1ns/1ps
`default_nettype none

module kmul_top (
  input  logic                     clk,
  input  logic                     rst,
  input  kmul_arith_pkg::operand_t a,
  input  kmul_arith_pkg::operand_t b,
  input  logic                     in_valid,
  output logic                     in_ready,
  output kmul_arith_pkg::product_t p,
  output logic                     out_valid,
  input  logic                     out_ready
);
  import kmul_arith_pkg::*;

  logic     ce;
  subprod_t z2;
  subprod_t z0;
  subprod_t p1;
  logic     exe_neg;
  logic     exe_valid;

  // Stall only when a result is held and not taken
  assign ce       = !out_valid || out_ready;
  assign in_ready = ce;

  kmul_split_if split ();

  kmul_split_stage u_split (
    .clk      (clk),
    .rst      (rst),
    .ce       (ce),
    .a        (a),
    .b        (b),
    .in_valid (in_valid && in_ready),
    .split    (split)
  );

  kmul_execute u_execute (
    .clk   (clk),
    .rst   (rst),
    .ce    (ce),
    .split (split),
    .z2    (z2),
    .z0    (z0),
    .p1    (p1),
    .neg   (exe_neg),
    .valid (exe_valid)
  );

  kmul_recombine u_recombine (
    .clk       (clk),
    .rst       (rst),
    .ce        (ce),
    .z2        (z2),
    .z0        (z0),
    .p1        (p1),
    .neg       (exe_neg),
    .in_valid  (exe_valid),
    .p         (p),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the Karatsuba multiplier testbench with Verilator and run it.
# The run passes only if the pass line shows up in the simulation output.
cd "$(dirname "$0")" \
  && verilator --binary --timing -f kmul.f --top-module kmul_tb -o kmul_sim \
  && ./obj_dir/kmul_sim | grep "RESULT: PASS" \
  && echo "kmul simulation passed" \
  || { echo "kmul simulation failed"; exit 1; }

// File: testbench/kmul_tb.sv
/*
 * Testbench for the 114 x 114 Karatsuba multiplier
 * Corner, latency, streaming and back-pressure runs against a reference product
 */
`timescale 1ns/1ps
`default_nettype none

module kmul_tb;
  import kmul_arith_pkg::*;
  import kmul_timing_pkg::*;

  // ==============================
  // Run sizing
  // ==============================
  localparam int RST_CYCLES  = 4;
  localparam int NUM_CORNER  = 12;
  localparam int NUM_RAND    = 300;
  // Accepted input to out_valid, cycles of high ce
  localparam int PIPE_LAT    = 9;
  // Corners, one latency probe, two random runs
  localparam int NUM_TXN     = NUM_CORNER + 1 + 2 * NUM_RAND;
  localparam int WATCHDOG_NS = NUM_TXN * (TOTAL_LAT + 4) * 10 + 2000;

  // Operand corners
  localparam operand_t ALL_ONES = '1;
  localparam operand_t HI_ONLY  = {{HALF_W{1'b1}}, {HALF_W{1'b0}}};
  localparam operand_t LO_ONLY  = {{HALF_W{1'b0}}, {HALF_W{1'b1}}};
  localparam half_t    EQ_HALF  = 57'h0a5a5a5a5a5a5a5;
  localparam operand_t EQ_BOTH  = {EQ_HALF, EQ_HALF};

  logic     clk;
  logic     rst;
  operand_t a;
  operand_t b;
  logic     in_valid;
  logic     in_ready;
  product_t p;
  logic     out_valid;
  logic     out_ready;

  // Scoreboard state
  product_t exp_q [$];
  product_t held_p;
  bit       hold_pending;
  bit       bp_mode;
  int       cyc;
  int       last_accept_cyc;
  int       last_out_cyc;
  int       base_cyc;

  kmul_top UUT (
    .clk       (clk),
    .rst       (rst),
    .a         (a),
    .b         (b),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .p         (p),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ==============================
  // Reference and checks
  // ==============================
  // Plain wide product of zero-extended operands
  function automatic product_t ref_product(input operand_t x, input operand_t y);
    return product_t'(x) * product_t'(y);
  endfunction

  function automatic operand_t random_operand();
    return operand_t'({$urandom(), $urandom(), $urandom(), $urandom()});
  endfunction

  task automatic check_value(input string name, input product_t got, input product_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // ==============================
  // Stimulus helpers
  // ==============================
  // Next edge plus drive skew, new out_ready under back-pressure
  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (bp_mode) begin
      out_ready = ($urandom_range(0, 1) == 1);
    end else begin
      out_ready = 1'b1;
    end
  endtask

  task automatic send_pair(input operand_t x, input operand_t y);
    // Random idle gaps only under back-pressure
    if (bp_mode) begin
      while ($urandom_range(0, 3) == 0) begin
        in_valid = 1'b0;
        next_cycle();
      end
    end
    a        = x;
    b        = y;
    in_valid = 1'b1;
    // Held until a negedge sees in_ready, transfer on the next edge
    @(negedge clk);
    while (!in_ready) begin
      next_cycle();
      @(negedge clk);
    end
    next_cycle();
    in_valid = 1'b0;
  endtask

  task automatic drain_pipeline();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  // ==============================
  // Scoreboard
  // ==============================
  // Sampled mid-cycle, transfers happen on the following edge
  always @(negedge clk) begin
    if (!rst) begin
      // Stalled result must stay put
      if (hold_pending) begin
        check_value("out_valid", product_t'(out_valid), product_t'(1'b1));
        check_value("p", p, held_p);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Output transfer seen with no input pending");
          $display("RESULT: FAIL");
          $fatal(1, "unexpected output");
        end else begin
          check_value("p", p, exp_q.pop_front());
          last_out_cyc = cyc;
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(ref_product(a, b));
        last_accept_cyc = cyc;
      end
      hold_pending = out_valid && !out_ready;
      held_p       = p;
    end
  end

  // Hang guard scaled by transaction count
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the pipeline stopped producing results", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    void'($urandom(32'hcd85));
    clk          = 1'b0;
    rst          = 1'b1;
    a            = '0;
    b            = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b1;
    bp_mode      = 1'b0;
    hold_pending = 1'b0;
    held_p       = '0;

    // Reset state, during reset and one cycle after
    repeat (RST_CYCLES) begin
      @(posedge clk);
      #1;
      check_value("out_valid", product_t'(out_valid), product_t'(1'b0));
      check_value("in_ready", product_t'(in_ready), product_t'(1'b1));
    end
    rst = 1'b0;
    next_cycle();
    check_value("out_valid", product_t'(out_valid), product_t'(1'b0));
    check_value("in_ready", product_t'(in_ready), product_t'(1'b1));

    // Corners, sign cases noted as (a_lo - a_hi, b_hi - b_lo)
    send_pair('0, '0);
    send_pair('0, ALL_ONES);
    send_pair(operand_t'(1), operand_t'(1));
    send_pair(operand_t'(1), ALL_ONES);
    send_pair(ALL_ONES, ALL_ONES);
    send_pair(HI_ONLY, LO_ONLY);   // both negative
    send_pair(HI_ONLY, HI_ONLY);   // first negative
    send_pair(LO_ONLY, LO_ONLY);   // second negative
    send_pair(LO_ONLY, HI_ONLY);
    send_pair(EQ_BOTH, ALL_ONES);  // zero difference
    send_pair(HI_ONLY, EQ_BOTH);
    send_pair(LO_ONLY, EQ_BOTH);
    drain_pipeline();

    // Isolated input into an empty pipeline
    send_pair(random_operand(), random_operand());
    do begin
      @(negedge clk);
    end while (!out_valid);
    check_value("latency", product_t'(cyc - last_accept_cyc), product_t'(PIPE_LAT));
    drain_pipeline();

    // Back-to-back stream, one result per cycle
    send_pair(random_operand(), random_operand());
    base_cyc = last_accept_cyc;
    repeat (NUM_RAND - 1) begin
      send_pair(random_operand(), random_operand());
    end
    drain_pipeline();
    check_value("stream span", product_t'(last_out_cyc - base_cyc),
                product_t'(NUM_RAND - 1 + PIPE_LAT));

    // Random in_valid and out_ready
    bp_mode = 1'b1;
    repeat (NUM_RAND) begin
      send_pair(random_operand(), random_operand());
    end
    bp_mode = 1'b0;

    // Full-rate drain, then idle so a stray trailing output is still seen
    repeat (PIPE_LAT + 4) begin
      next_cycle();
    end

    if (exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("%0d results never arrived", exp_q.size());
      $display("RESULT: FAIL");
      $fatal(1, "results missing");
    end
  end

endmodule

`default_nettype wire
